/* lsu_exe_top.f */
+incdir+common
common/mips_pkg.sv
common/lsu_pkg.sv
common/lsu_req_if.sv
lsu/lsu_agu.sv
lsu/lsu_req_queue.sv
lsu/lsu_sram_port.sv
hdl/lsu_exe_top.sv
tests/tb_lsu_exe_top.sv

/* run_sim.sh */
#!/bin/sh
# build and run the lsu testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f lsu_exe_top.f --top-module tb_lsu_exe_top -o tb_lsu_exe_top

out=$(./obj_dir/tb_lsu_exe_top)
echo "$out"

if echo "$out" | grep -qx "TESTBENCH PASSED"; then
    exit 0
fi
exit 1

/* tests/tb_lsu_exe_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "lsu_defs.svh"

module tb_lsu_exe_top;

    localparam int BP_OPS     = 200;
    // 13 legal loads plus 15 stores plus 12 misaligned cases, all run twice
    localparam int TOTAL_OPS  = 2 * (13 + 15 + 12) + BP_OPS;
    localparam int TIMEOUT_NS = 20 * 4 * TOTAL_OPS + 100;

    typedef enum int {K_LB, K_LBU, K_LH, K_LHU, K_LW, K_SB, K_SH, K_SWL, K_SWR, K_SW} kind_e;

    typedef struct packed {
        logic [`LSU_ADDR_W-1:0] addr;
        logic                   wr;
        logic [`LSU_STRB_W-1:0] wstrb;
        logic [`LSU_DATA_W-1:0] wdata;
        lsu_pkg::ld_view_t      ld_op;
        mips_pkg::reg_idx_t     dest;
        logic [`LSU_ADDR_W-1:0] pc;
        mips_pkg::ex_code_t     ex_code;
    } exp_t;

    logic                     clk;
    logic                     reset;
    logic                     ds_to_es_valid;
    logic                     es_allowin;
    lsu_pkg::mem_op_u         ds_op;
    logic                     ds_is_store;
    logic [`LSU_ADDR_W-1:0]   ds_base;
    logic [`LSU_OFFSET_W-1:0] ds_offset;
    logic [`LSU_DATA_W-1:0]   ds_rt_value;
    mips_pkg::reg_idx_t       ds_dest;
    logic [`LSU_ADDR_W-1:0]   ds_pc;
    logic                     data_sram_en;
    logic                     data_sram_wr;
    logic [`LSU_STRB_W-1:0]   data_sram_wstrb;
    logic [`LSU_ADDR_W-1:0]   data_sram_addr;
    logic [`LSU_DATA_W-1:0]   data_sram_wdata;
    logic                     data_sram_addr_ok;
    logic                     es_to_ms_valid;
    logic                     ms_allowin;
    lsu_pkg::ld_view_t        ms_ld_op;
    lsu_pkg::byte_off_t       ms_byte_off;
    mips_pkg::reg_idx_t       ms_dest;
    logic [`LSU_ADDR_W-1:0]   ms_pc;
    mips_pkg::ex_code_t       ms_ex_code;
    logic [`LSU_ADDR_W-1:0]   ms_bad_vaddr;
    logic                     ms_mem_access;

    exp_t        ms_q[$];
    exp_t        sram_q[$];
    exp_t        ms_head;
    exp_t        sram_head;
    logic        ms_head_ok;
    logic        sram_head_ok;
    logic        ms_fire;
    logic        sram_fire;
    int          err_count;
    int          op_count;
    int          stall_pct;
    logic [31:0] next_pc;

    lsu_exe_top u_dut (.*);

    always #2 clk = ~clk;

    function automatic void note_mismatch(string msg);
        err_count++;
        $display("MISMATCH at %0t ns: %s", $time, msg);
    endfunction

    function automatic void note_failure(string msg);
        err_count++;
        $display("ERROR at %0t ns: %s", $time, msg);
    endfunction

    // word accesses need offset 0 and halfword accesses an even offset
    function automatic logic offset_ok(kind_e kind, logic [1:0] off);
        if (kind == K_LW || kind == K_SW) begin
            return off == 2'd0;
        end
        if (kind == K_LH || kind == K_LHU || kind == K_SH) begin
            return !off[0];
        end
        return 1'b1;
    endfunction

    function automatic lsu_pkg::mem_op_u encode_op(kind_e kind);
        lsu_pkg::mem_op_u op;
        op = '0;
        case (kind)
            K_LB:    op.ld.lb = 1'b1;
            K_LBU:   op.ld.lbu = 1'b1;
            K_LH:    op.ld.lh = 1'b1;
            K_LHU:   op.ld.lhu = 1'b1;
            K_SB:    op.st.sb = 1'b1;
            K_SH:    op.st.sh = 1'b1;
            K_SWL:   op.st.swl = 1'b1;
            K_SWR:   op.st.swr = 1'b1;
            default: op = '0;
        endcase
        return op;
    endfunction

    function automatic exp_t expect_op(kind_e kind, logic [31:0] base, logic [15:0] offset,
                                       logic [31:0] rt, mips_pkg::reg_idx_t dest,
                                       logic [31:0] pc);
        exp_t             e;
        lsu_pkg::mem_op_u op;
        logic [1:0]       off;
        logic             store;
        int               gap;
        op      = encode_op(kind);
        store   = (kind >= K_SB);
        e.addr  = base + {{16{offset[15]}}, offset};
        off     = e.addr[1:0];
        gap     = 3 - int'(off);
        e.wr    = store;
        e.dest  = dest;
        e.pc    = pc;
        e.ld_op = store ? '0 : op.ld;
        e.wdata = rt;
        e.wstrb = '0;
        case (kind)
            K_SB: begin
                e.wdata      = rt[7:0] * 32'h0101_0101;
                e.wstrb[off] = 1'b1;
            end
            K_SH: begin
                e.wdata = rt[15:0] * 32'h0001_0001;
                e.wstrb = 4'b0011 << off;
            end
            K_SWL: begin
                e.wdata = rt >> (8 * gap);
                e.wstrb = 4'b1111 >> gap;
            end
            K_SWR: begin
                e.wdata = rt << (8 * off);
                e.wstrb = 4'b1111 << off;
            end
            K_SW:    e.wstrb = 4'b1111;
            default: e.wstrb = '0;
        endcase
        e.ex_code = mips_pkg::NO_EX;
        if (!offset_ok(kind, off)) begin
            e.ex_code = store ? mips_pkg::ADES : mips_pkg::ADEL;
            e.wstrb   = '0;
        end
        return e;
    endfunction

    // starts and returns 1 ns after a rising edge
    task automatic issue_op(kind_e kind, logic [1:0] want_off);
        logic [31:0] base;
        logic [15:0] offset;
        logic [31:0] sum;
        logic [1:0]  fix;
        exp_t        e;
        base   = $urandom;
        offset = 16'($urandom);
        sum    = base + {{16{offset[15]}}, offset};
        fix    = want_off - sum[1:0];
        base   = base + 32'(fix);
        ds_to_es_valid = 1'b1;
        ds_op          = encode_op(kind);
        ds_is_store    = (kind >= K_SB);
        ds_base        = base;
        ds_offset      = offset;
        ds_rt_value    = $urandom;
        ds_dest        = mips_pkg::reg_idx_t'($urandom % 32);
        ds_pc          = next_pc;
        e = expect_op(kind, base, offset, ds_rt_value, ds_dest, ds_pc);
        @(negedge clk);
        while (!es_allowin) @(negedge clk);
        ms_q.push_back(e);
        if (e.ex_code == mips_pkg::NO_EX) begin
            sram_q.push_back(e);
        end
        next_pc  = next_pc + 4;
        op_count = op_count + 1;
        @(posedge clk);
        #1;
        ds_to_es_valid = 1'b0;
    endtask

    task automatic run_cases(bit want_legal, kind_e first, kind_e last);
        for (int rep = 0; rep < 2; rep++) begin
            for (int k = first; k <= last; k++) begin
                for (int o = 0; o < 4; o++) begin
                    if (offset_ok(kind_e'(k), 2'(o)) == want_legal) begin
                        issue_op(kind_e'(k), 2'(o));
                    end
                end
            end
        end
    endtask

    task automatic finish_test(string name, int first_op, int errs_before);
        while (ms_q.size() != 0) @(posedge clk);
        @(posedge clk);
        #1;
        assert (sram_q.size() == 0) else note_failure("sram requests left over after drain");
        $display("test %s: %0d ops, %0d errors", name, op_count - first_op,
                 err_count - errs_before);
    endtask

    // handshakes are stable from the falling edge to the next rising edge
    always @(negedge clk) begin
        ms_fire   <= !reset && es_to_ms_valid && ms_allowin;
        sram_fire <= !reset && data_sram_en && data_sram_addr_ok;
    end

    always @(posedge clk) begin
        if (ms_fire && ms_q.size() != 0) begin
            void'(ms_q.pop_front());
        end
        if (sram_fire && sram_q.size() != 0) begin
            void'(sram_q.pop_front());
        end
        ms_head_ok   <= (ms_q.size() != 0);
        sram_head_ok <= (sram_q.size() != 0);
        if (ms_q.size() != 0) begin
            ms_head <= ms_q[0];
        end
        if (sram_q.size() != 0) begin
            sram_head <= sram_q[0];
        end
    end

    always @(posedge clk) begin
        #1;
        ms_allowin        = ($urandom % 100) >= stall_pct;
        data_sram_addr_ok = ($urandom % 100) >= stall_pct;
    end

    a_ms_expected: assert property (@(posedge clk) disable iff (reset)
        (es_to_ms_valid && ms_allowin) |-> ms_head_ok)
        else note_failure("memory stage took an operation that was never issued");

    a_ms_fields: assert property (@(posedge clk) disable iff (reset)
        (es_to_ms_valid && ms_allowin && ms_head_ok) |->
            (ms_pc == ms_head.pc && ms_dest == ms_head.dest && ms_ld_op == ms_head.ld_op &&
             ms_ex_code == ms_head.ex_code && ms_byte_off == ms_head.addr[1:0] &&
             ms_bad_vaddr == ((ms_head.ex_code == mips_pkg::NO_EX) ? '0 : ms_head.addr) &&
             ms_mem_access == (ms_head.ex_code == mips_pkg::NO_EX)))
        else note_mismatch("memory stage handover differs from the next expected op");

    a_sram_expected: assert property (@(posedge clk) disable iff (reset)
        (data_sram_en && data_sram_addr_ok) |-> sram_head_ok)
        else note_failure("sram accepted a request that should not exist");

    a_sram_fields: assert property (@(posedge clk) disable iff (reset)
        (data_sram_en && data_sram_addr_ok && sram_head_ok) |->
            (data_sram_addr == sram_head.addr && data_sram_wr == sram_head.wr &&
             data_sram_wstrb == sram_head.wstrb &&
             (!sram_head.wr || data_sram_wdata == sram_head.wdata)))
        else note_mismatch("sram request differs from the next expected access");

    a_sram_hold: assert property (@(posedge clk) disable iff (reset)
        (data_sram_en && !data_sram_addr_ok) |=>
            (data_sram_en && $stable(data_sram_addr) && $stable(data_sram_wr) &&
             $stable(data_sram_wstrb) && $stable(data_sram_wdata)))
        else note_failure("sram request dropped or changed before addr_ok");

    initial begin
        #(TIMEOUT_NS);
        $display("watchdog: run did not finish within %0d ns", TIMEOUT_NS);
        $display("TESTBENCH FAILED");
        $finish;
    end

    initial begin
        int errs;
        int first;
        void'($urandom(32'h47f4_245c));
        clk               = 1'b0;
        reset             = 1'b1;
        ds_to_es_valid    = 1'b0;
        ds_op             = '0;
        ds_is_store       = 1'b0;
        ds_base           = '0;
        ds_offset         = '0;
        ds_rt_value       = '0;
        ds_dest           = '0;
        ds_pc             = '0;
        ms_allowin        = 1'b1;
        data_sram_addr_ok = 1'b1;
        ms_fire           = 1'b0;
        sram_fire         = 1'b0;
        ms_head_ok        = 1'b0;
        sram_head_ok      = 1'b0;
        err_count         = 0;
        op_count          = 0;
        stall_pct         = 0;
        next_pc           = 32'hbfc0_0000;
        repeat (2) @(posedge clk);
        #1;
        reset = 1'b0;

        errs = err_count;
        @(negedge clk);
        assert (es_allowin && !es_to_ms_valid && !data_sram_en)
            else note_failure("outputs not idle after reset");
        @(posedge clk);
        #1;
        $display("test reset: 0 ops, %0d errors", err_count - errs);

        errs  = err_count;
        first = op_count;
        run_cases(1'b1, K_LB, K_LW);
        finish_test("aligned loads", first, errs);

        errs  = err_count;
        first = op_count;
        run_cases(1'b1, K_SB, K_SW);
        finish_test("stores", first, errs);

        errs  = err_count;
        first = op_count;
        run_cases(1'b0, K_LB, K_SW);
        finish_test("misalignment", first, errs);

        // random stalls from the memory stage and the sram
        errs      = err_count;
        first     = op_count;
        stall_pct = 40;
        for (int i = 0; i < BP_OPS; i++) begin
            issue_op(kind_e'($urandom % 10), 2'($urandom % 4));
            if ($urandom % 4 == 0) begin
                @(posedge clk);
                #1;
            end
        end
        finish_test("back-pressure", first, errs);

        $display("summary: 5 tests, %0d ops, %0d errors", op_count, err_count);
        if (err_count == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* hdl/lsu_exe_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "lsu_defs.svh"

module lsu_exe_top (
    input  wire                        clk,
    input  wire                        reset,
    // from decode
    input  wire                        ds_to_es_valid,
    output logic                       es_allowin,
    input  lsu_pkg::mem_op_u           ds_op,
    input  wire                        ds_is_store,
    input  wire [`LSU_ADDR_W-1:0]      ds_base,
    input  wire [`LSU_OFFSET_W-1:0]    ds_offset,
    input  wire [`LSU_DATA_W-1:0]      ds_rt_value,
    input  mips_pkg::reg_idx_t         ds_dest,
    input  wire [`LSU_ADDR_W-1:0]      ds_pc,
    // data sram
    output logic                       data_sram_en,
    output logic                       data_sram_wr,
    output logic [`LSU_STRB_W-1:0]     data_sram_wstrb,
    output logic [`LSU_ADDR_W-1:0]     data_sram_addr,
    output logic [`LSU_DATA_W-1:0]     data_sram_wdata,
    input  wire                        data_sram_addr_ok,
    // to memory stage
    output logic                       es_to_ms_valid,
    input  wire                        ms_allowin,
    output lsu_pkg::ld_view_t          ms_ld_op,
    output lsu_pkg::byte_off_t         ms_byte_off,
    output mips_pkg::reg_idx_t         ms_dest,
    output logic [`LSU_ADDR_W-1:0]     ms_pc,
    output mips_pkg::ex_code_t         ms_ex_code,
    output logic [`LSU_ADDR_W-1:0]     ms_bad_vaddr,
    output logic                       ms_mem_access
);

    lsu_req_if agu_to_queue ();
    lsu_req_if queue_to_port ();

    lsu_agu u_agu (
        .clk         (clk),
        .reset       (reset),
        .in_valid    (ds_to_es_valid),
        .in_op       (ds_op),
        .in_is_store (ds_is_store),
        .in_base     (ds_base),
        .in_offset   (ds_offset),
        .in_rt_value (ds_rt_value),
        .in_dest     (ds_dest),
        .in_pc       (ds_pc),
        .in_allowin  (es_allowin),
        .req         (agu_to_queue.src)
    );

    lsu_req_queue u_queue (
        .clk     (clk),
        .reset   (reset),
        .wr_side (agu_to_queue.dst),
        .rd_side (queue_to_port.src)
    );

    lsu_sram_port u_port (
        .clk               (clk),
        .reset             (reset),
        .req               (queue_to_port.dst),
        .data_sram_en      (data_sram_en),
        .data_sram_wr      (data_sram_wr),
        .data_sram_wstrb   (data_sram_wstrb),
        .data_sram_addr    (data_sram_addr),
        .data_sram_wdata   (data_sram_wdata),
        .data_sram_addr_ok (data_sram_addr_ok),
        .es_to_ms_valid    (es_to_ms_valid),
        .ms_allowin        (ms_allowin),
        .ms_ld_op          (ms_ld_op),
        .ms_byte_off       (ms_byte_off),
        .ms_dest           (ms_dest),
        .ms_pc             (ms_pc),
        .ms_ex_code        (ms_ex_code),
        .ms_bad_vaddr      (ms_bad_vaddr),
        .ms_mem_access     (ms_mem_access)
    );

endmodule

`default_nettype wire

/* lsu/lsu_sram_port.sv */
`timescale 1ns/1ps
`default_nettype none

`include "lsu_defs.svh"

module lsu_sram_port (
    input  wire                        clk,
    input  wire                        reset,
    lsu_req_if.dst                     req,
    output logic                       data_sram_en,
    output logic                       data_sram_wr,
    output logic [`LSU_STRB_W-1:0]     data_sram_wstrb,
    output logic [`LSU_ADDR_W-1:0]     data_sram_addr,
    output logic [`LSU_DATA_W-1:0]     data_sram_wdata,
    input  wire                        data_sram_addr_ok,
    output logic                       es_to_ms_valid,
    input  wire                        ms_allowin,
    output lsu_pkg::ld_view_t          ms_ld_op,
    output lsu_pkg::byte_off_t         ms_byte_off,
    output mips_pkg::reg_idx_t         ms_dest,
    output logic [`LSU_ADDR_W-1:0]     ms_pc,
    output mips_pkg::ex_code_t         ms_ex_code,
    output logic [`LSU_ADDR_W-1:0]     ms_bad_vaddr,
    output logic                       ms_mem_access
);

    logic has_ex;
    logic req_pending;
    logic addr_taken;
    logic sram_done;

    assign has_ex = (req.ex_code != mips_pkg::NO_EX);

    // start only when ms can take it, but never drop a request once raised
    assign data_sram_en = req.valid && !has_ex && !addr_taken &&
                          (ms_allowin || req_pending);
    assign sram_done    = addr_taken || (data_sram_en && data_sram_addr_ok);

    assign es_to_ms_valid = req.valid && (has_ex || sram_done);
    assign req.allowin    = ms_allowin && (has_ex || sram_done);

    always_ff @(posedge clk) begin
        if (reset) begin
            req_pending <= 1'b0;
            addr_taken  <= 1'b0;
        end else begin
            req_pending <= data_sram_en && !data_sram_addr_ok;
            // address accepted while ms stalled and the item still at the head
            if (req.valid && req.allowin) begin
                addr_taken <= 1'b0;
            end else if (data_sram_en && data_sram_addr_ok) begin
                addr_taken <= 1'b1;
            end
        end
    end

    assign data_sram_wr    = req.wr;
    assign data_sram_wstrb = req.wstrb;
    assign data_sram_addr  = req.addr;
    assign data_sram_wdata = req.wdata;

    assign ms_ld_op      = req.ld_op;
    assign ms_byte_off   = req.addr[1:0];
    assign ms_dest       = req.dest;
    assign ms_pc         = req.pc;
    assign ms_ex_code    = req.ex_code;
    assign ms_bad_vaddr  = has_ex ? req.addr : '0;
    assign ms_mem_access = !has_ex;

    // an exception item carries no strobes and never reaches the sram
    a_no_sram_on_ex: assert property (@(posedge clk) disable iff (reset)
        (req.valid && has_ex) |-> (!data_sram_en && req.wstrb == '0));

    a_strb_only_on_write: assert property (@(posedge clk) disable iff (reset)
        (data_sram_en && data_sram_wstrb != '0) |-> data_sram_wr);

    a_req_stable: assert property (@(posedge clk) disable iff (reset)
        req_pending |-> (data_sram_en && $stable(data_sram_addr) && $stable(data_sram_wr) &&
                         $stable(data_sram_wstrb) && $stable(data_sram_wdata)));

endmodule

`default_nettype wire

/* lsu/lsu_req_queue.sv */
`timescale 1ns/1ps
`default_nettype none

`include "lsu_defs.svh"

module lsu_req_queue (
    input  wire        clk,
    input  wire        reset,
    lsu_req_if.dst     wr_side,
    lsu_req_if.src     rd_side
);

    localparam int PTR_W = $clog2(`LSU_QUEUE_DEPTH);
    localparam int CNT_W = $clog2(`LSU_QUEUE_DEPTH + 1);

    logic [`LSU_ADDR_W-1:0]   addr_q  [`LSU_QUEUE_DEPTH];
    logic                     wr_q    [`LSU_QUEUE_DEPTH];
    logic [`LSU_STRB_W-1:0]   wstrb_q [`LSU_QUEUE_DEPTH];
    logic [`LSU_DATA_W-1:0]   wdata_q [`LSU_QUEUE_DEPTH];
    lsu_pkg::ld_view_t        ld_op_q [`LSU_QUEUE_DEPTH];
    mips_pkg::reg_idx_t       dest_q  [`LSU_QUEUE_DEPTH];
    logic [`LSU_ADDR_W-1:0]   pc_q    [`LSU_QUEUE_DEPTH];
    mips_pkg::ex_code_t       ex_q    [`LSU_QUEUE_DEPTH];

    logic [PTR_W-1:0]         rd_ptr;
    logic [PTR_W-1:0]         wr_ptr;
    logic [CNT_W-1:0]         count;
    logic                     full;
    logic                     push;
    logic                     pop;

    assign full = (count == CNT_W'(`LSU_QUEUE_DEPTH));

    // a full queue still takes an item on the edge the head leaves
    assign wr_side.allowin = !full || rd_side.allowin;
    assign rd_side.valid   = (count != '0);

    assign push = wr_side.valid && wr_side.allowin;
    assign pop  = rd_side.valid && rd_side.allowin;

    always_ff @(posedge clk) begin
        if (reset) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(`LSU_QUEUE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(`LSU_QUEUE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            addr_q[wr_ptr]  <= wr_side.addr;
            wr_q[wr_ptr]    <= wr_side.wr;
            wstrb_q[wr_ptr] <= wr_side.wstrb;
            wdata_q[wr_ptr] <= wr_side.wdata;
            ld_op_q[wr_ptr] <= wr_side.ld_op;
            dest_q[wr_ptr]  <= wr_side.dest;
            pc_q[wr_ptr]    <= wr_side.pc;
            ex_q[wr_ptr]    <= wr_side.ex_code;
        end
    end

    assign rd_side.addr    = addr_q[rd_ptr];
    assign rd_side.wr      = wr_q[rd_ptr];
    assign rd_side.wstrb   = wstrb_q[rd_ptr];
    assign rd_side.wdata   = wdata_q[rd_ptr];
    assign rd_side.ld_op   = ld_op_q[rd_ptr];
    assign rd_side.dest    = dest_q[rd_ptr];
    assign rd_side.pc      = pc_q[rd_ptr];
    assign rd_side.ex_code = ex_q[rd_ptr];

    // an overflow or an underflow pushes the count out of range
    a_count_in_range: assert property (@(posedge clk) disable iff (reset)
        count <= CNT_W'(`LSU_QUEUE_DEPTH));

    // pointers meet only when empty or full
    a_ptr_count_agree: assert property (@(posedge clk) disable iff (reset)
        (rd_ptr == wr_ptr) == (count == '0 || full));

endmodule

`default_nettype wire

/* lsu/lsu_agu.sv */
`timescale 1ns/1ps
`default_nettype none

`include "lsu_defs.svh"

module lsu_agu (
    input  wire                        clk,
    input  wire                        reset,
    input  wire                        in_valid,
    input  lsu_pkg::mem_op_u           in_op,
    input  wire                        in_is_store,
    input  wire [`LSU_ADDR_W-1:0]      in_base,
    input  wire [`LSU_OFFSET_W-1:0]    in_offset,
    input  wire [`LSU_DATA_W-1:0]      in_rt_value,
    input  mips_pkg::reg_idx_t         in_dest,
    input  wire [`LSU_ADDR_W-1:0]      in_pc,
    output logic                       in_allowin,
    lsu_req_if.src                     req
);

    logic                       es_valid;
    lsu_pkg::mem_op_u           op_r;
    logic                       is_store_r;
    logic [`LSU_ADDR_W-1:0]     base_r;
    logic [`LSU_OFFSET_W-1:0]   offset_r;
    logic [`LSU_DATA_W-1:0]     rt_r;
    mips_pkg::reg_idx_t         dest_r;
    logic [`LSU_ADDR_W-1:0]     pc_r;

    lsu_pkg::ld_view_t          ld;
    lsu_pkg::st_view_t          st;
    lsu_pkg::byte_off_t         byte_off;
    lsu_pkg::acc_size_e         acc_size;
    logic                       misaligned;
    logic [`LSU_STRB_W-1:0]     strb_raw;

    // stage register, no ready_go condition here
    assign in_allowin = !es_valid || req.allowin;

    always_ff @(posedge clk) begin
        if (reset) begin
            es_valid <= 1'b0;
        end else if (in_allowin) begin
            es_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_allowin) begin
            op_r       <= in_op;
            is_store_r <= in_is_store;
            base_r     <= in_base;
            offset_r   <= in_offset;
            rt_r       <= in_rt_value;
            dest_r     <= in_dest;
            pc_r       <= in_pc;
        end
    end

    assign ld = op_r.ld;
    assign st = op_r.st;

    assign req.addr = base_r +
        {{(`LSU_ADDR_W-`LSU_OFFSET_W){offset_r[`LSU_OFFSET_W-1]}}, offset_r};
    assign byte_off = req.addr[1:0];

    always_comb begin
        if (is_store_r) begin
            if (st.sb) begin
                acc_size = lsu_pkg::ACC_BYTE;
            end else if (st.sh) begin
                acc_size = lsu_pkg::ACC_HALF;
            end else if (st.swl || st.swr) begin
                acc_size = lsu_pkg::ACC_PART;
            end else begin
                acc_size = lsu_pkg::ACC_WORD;
            end
        end else begin
            if (ld.lb || ld.lbu) begin
                acc_size = lsu_pkg::ACC_BYTE;
            end else if (ld.lh || ld.lhu) begin
                acc_size = lsu_pkg::ACC_HALF;
            end else begin
                acc_size = lsu_pkg::ACC_WORD;
            end
        end
    end

    // swl/swr are legal at any offset
    assign misaligned = (acc_size == lsu_pkg::ACC_WORD && byte_off != 2'b00) ||
                        (acc_size == lsu_pkg::ACC_HALF && byte_off[0]);

    always_comb begin
        if (!misaligned) begin
            req.ex_code = mips_pkg::NO_EX;
        end else if (is_store_r) begin
            req.ex_code = mips_pkg::ADES;
        end else begin
            req.ex_code = mips_pkg::ADEL;
        end
    end

    // store data lane placement
    always_comb begin
        req.wdata = rt_r;
        strb_raw  = 4'b1111;
        if (st.sb) begin
            req.wdata = {4{rt_r[7:0]}};
            strb_raw  = 4'b0001 << byte_off;
        end else if (st.sh) begin
            req.wdata = {2{rt_r[15:0]}};
            strb_raw  = byte_off[1] ? 4'b1100 : 4'b0011;
        end else if (st.swl) begin
            case (byte_off)
                2'd0:    begin req.wdata = {24'b0, rt_r[31:24]}; strb_raw = 4'b0001; end
                2'd1:    begin req.wdata = {16'b0, rt_r[31:16]}; strb_raw = 4'b0011; end
                2'd2:    begin req.wdata = {8'b0, rt_r[31:8]};   strb_raw = 4'b0111; end
                default: begin req.wdata = rt_r;                 strb_raw = 4'b1111; end
            endcase
        end else if (st.swr) begin
            case (byte_off)
                2'd0:    begin req.wdata = rt_r;                 strb_raw = 4'b1111; end
                2'd1:    begin req.wdata = {rt_r[23:0], 8'b0};   strb_raw = 4'b1110; end
                2'd2:    begin req.wdata = {rt_r[15:0], 16'b0};  strb_raw = 4'b1100; end
                default: begin req.wdata = {rt_r[7:0], 24'b0};   strb_raw = 4'b1000; end
            endcase
        end
    end

    assign req.wstrb = (is_store_r && !misaligned) ? strb_raw : '0;
    assign req.wr    = is_store_r;
    assign req.ld_op = is_store_r ? '0 : ld;
    assign req.valid = es_valid;
    assign req.dest  = dest_r;
    assign req.pc    = pc_r;

    // a stalled item must not be overwritten by a new acceptance
    a_hold_when_stalled: assert property (@(posedge clk) disable iff (reset)
        (req.valid && !req.allowin) |=>
            (req.valid && $stable(req.pc) && $stable(req.addr) && $stable(req.wdata)));

endmodule

`default_nettype wire

/* common/lsu_req_if.sv */
`timescale 1ns/1ps
`default_nettype none

`include "lsu_defs.svh"

interface lsu_req_if;

    // handshake
    logic                     valid;
    logic                     allowin;

    // sram side of the request
    logic [`LSU_ADDR_W-1:0]   addr;
    logic                     wr;
    logic [`LSU_STRB_W-1:0]   wstrb;
    logic [`LSU_DATA_W-1:0]   wdata;

    // carried on to the memory stage
    lsu_pkg::ld_view_t        ld_op;
    mips_pkg::reg_idx_t       dest;
    logic [`LSU_ADDR_W-1:0]   pc;
    mips_pkg::ex_code_t       ex_code;

    modport src (
        output valid, addr, wr, wstrb, wdata, ld_op, dest, pc, ex_code,
        input  allowin
    );

    modport dst (
        input  valid, addr, wr, wstrb, wdata, ld_op, dest, pc, ex_code,
        output allowin
    );

endinterface

`default_nettype wire

/* common/lsu_pkg.sv */
`default_nettype none

package lsu_pkg;

    // load view, all zero means LW
    typedef struct packed {
        logic lb;
        logic lbu;
        logic lh;
        logic lhu;
    } ld_view_t;

    // store view, all zero means SW
    typedef struct packed {
        logic sb;
        logic sh;
        logic swl;
        logic swr;
    } st_view_t;

    // one op word from decode, is_store picks the view
    typedef union packed {
        ld_view_t ld;
        st_view_t st;
    } mem_op_u;

    // access kind, decides the alignment rule
    typedef enum logic [1:0] {
        ACC_BYTE,
        ACC_HALF,
        ACC_WORD,
        ACC_PART
    } acc_size_e;

    // low two address bits
    typedef logic [1:0] byte_off_t;

endpackage

`default_nettype wire

/* common/mips_pkg.sv */
`default_nettype none

package mips_pkg;

    // general purpose register index
    typedef logic [4:0] reg_idx_t;

    // cp0 cause.exccode values used by this slice
    // NO_EX is the all-ones pattern the pipeline carries when nothing is raised
    typedef enum logic [4:0] {
        ADEL  = 5'h04,
        ADES  = 5'h05,
        NO_EX = 5'h1f
    } ex_code_t;

endpackage

`default_nettype wire

/* common/lsu_defs.svh */
`ifndef LSU_DEFS_SVH
`define LSU_DEFS_SVH

// address and data path widths
`define LSU_ADDR_W 32
`define LSU_DATA_W 32

// one strobe bit per byte lane
`define LSU_STRB_W 4

// immediate field of the load/store encoding
`define LSU_OFFSET_W 16

// entries between the execute register and the sram port
`define LSU_QUEUE_DEPTH 2

`endif
